//--- common/gb_alu_pkg.sv
package gb_alu_pkg;

    // ALU operation codes
    localparam logic [4:0] op_add  = 5'b00000;
    localparam logic [4:0] op_adc  = 5'b00001;
    localparam logic [4:0] op_sub  = 5'b00010;
    localparam logic [4:0] op_sbc  = 5'b00011;
    localparam logic [4:0] op_and  = 5'b00100;
    localparam logic [4:0] op_xor  = 5'b00101;
    localparam logic [4:0] op_or   = 5'b00110;
    localparam logic [4:0] op_cp   = 5'b00111;
    localparam logic [4:0] op_rlc  = 5'b01000;
    localparam logic [4:0] op_rrc  = 5'b01001;
    localparam logic [4:0] op_rl   = 5'b01010;
    localparam logic [4:0] op_rr   = 5'b01011;
    localparam logic [4:0] op_sla  = 5'b01100;
    localparam logic [4:0] op_sra  = 5'b01101;
    localparam logic [4:0] op_swap = 5'b01110;
    localparam logic [4:0] op_srl  = 5'b01111;
    localparam logic [4:0] op_lf   = 5'b10000;  // Reserved, no fetch path here
    localparam logic [4:0] op_sf   = 5'b10010;  // Reserved as well
    localparam logic [4:0] op_daa  = 5'b10100;
    localparam logic [4:0] op_cpl  = 5'b10101;
    localparam logic [4:0] op_scf  = 5'b10110;
    localparam logic [4:0] op_ccf  = 5'b10111;
    localparam logic [4:0] op_ld   = 5'b11000;  // Falls to the ALU default path
    localparam logic [4:0] op_bit  = 5'b11101;
    localparam logic [4:0] op_res  = 5'b11110;
    localparam logic [4:0] op_set  = 5'b11111;

    // Bit positions in the 4-bit flag word
    localparam int flag_z = 3;
    localparam int flag_n = 2;
    localparam int flag_h = 1;
    localparam int flag_c = 0;

    // Register field codes
    localparam logic [2:0] reg_b      = 3'd0;
    localparam logic [2:0] reg_c      = 3'd1;
    localparam logic [2:0] reg_d      = 3'd2;
    localparam logic [2:0] reg_e      = 3'd3;
    localparam logic [2:0] reg_h      = 3'd4;
    localparam logic [2:0] reg_l      = 3'd5;
    localparam logic [2:0] reg_hl_mem = 3'd6;
    localparam logic [2:0] reg_a      = 3'd7;

    // Main page opcodes matched as whole bytes
    localparam logic [7:0] opc_rlca = 8'h07;
    localparam logic [7:0] opc_rrca = 8'h0f;
    localparam logic [7:0] opc_rla  = 8'h17;
    localparam logic [7:0] opc_rra  = 8'h1f;
    localparam logic [7:0] opc_daa  = 8'h27;
    localparam logic [7:0] opc_cpl  = 8'h2f;
    localparam logic [7:0] opc_scf  = 8'h37;
    localparam logic [7:0] opc_ccf  = 8'h3f;

    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
    } gb_opcode_fields_t;

    typedef union packed {
        logic [7:0]        raw;
        gb_opcode_fields_t fields;
    } gb_opcode_t;

endpackage

//--- rtl/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder
    import gb_alu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       instr_valid,
    input  logic       instr_cb,
    input  logic [7:0] instr,
    input  logic [7:0] imm,
    output logic       dec_valid,
    output logic       dec_illegal,
    output logic [4:0] dec_op,
    output logic [2:0] dec_dst,
    output logic [2:0] dec_src,
    output logic       dec_src_imm,
    output logic [7:0] dec_imm,
    output logic [2:0] dec_bit_index,
    output logic       dec_keep_z,
    output logic       dec_write
);

    gb_opcode_t op;
    logic       legal;
    logic [4:0] op_n;
    logic [2:0] dst_n;
    logic       src_imm_n;
    logic       keep_z_n;
    logic       write_n;

    assign op = instr;

    //////////////////////////////
    // Decode
    //////////////////////////////

    always_comb begin
        legal     = 1'b1;
        op_n      = op_ld;
        dst_n     = reg_a;
        src_imm_n = 1'b0;
        keep_z_n  = 1'b0;
        if (instr_cb) begin
            // Shift group, BIT, RES or SET on register z
            dst_n = op.fields.z;
            case (op.fields.x)
                2'd0:    op_n = {2'b01, op.fields.y};
                2'd1:    op_n = op_bit;
                2'd2:    op_n = op_res;
                default: op_n = op_set;
            endcase
            legal = (op.fields.z != reg_hl_mem);
        end else begin
            case (op.raw)
                opc_rlca: begin
                    op_n     = op_rlc;
                    keep_z_n = 1'b1;
                end
                opc_rrca: begin
                    op_n     = op_rrc;
                    keep_z_n = 1'b1;
                end
                opc_rla: begin
                    op_n     = op_rl;
                    keep_z_n = 1'b1;
                end
                opc_rra: begin
                    op_n     = op_rr;
                    keep_z_n = 1'b1;
                end
                opc_daa: op_n = op_daa;
                opc_cpl: op_n = op_cpl;
                opc_scf: op_n = op_scf;
                opc_ccf: op_n = op_ccf;
                default: begin
                    if (op.fields.x == 2'd0 && op.fields.z == 3'd6) begin
                        // LD r,n
                        dst_n     = op.fields.y;
                        src_imm_n = 1'b1;
                        legal     = (op.fields.y != reg_hl_mem);
                    end else if (op.fields.x == 2'd2) begin
                        op_n  = {2'b00, op.fields.y};
                        legal = (op.fields.z != reg_hl_mem);
                    end else if (op.fields.x == 2'd3 && op.fields.z == 3'd6) begin
                        op_n      = {2'b00, op.fields.y};
                        src_imm_n = 1'b1;
                    end else begin
                        legal = 1'b0;
                    end
                end
            endcase
        end
        // BIT and CP touch only the flags
        write_n = (op_n != op_cp) && (op_n != op_bit);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid   <= 1'b0;
            dec_illegal <= 1'b0;
        end else begin
            dec_valid   <= instr_valid & legal;
            dec_illegal <= instr_valid & ~legal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_op        <= op_n;
            dec_dst       <= dst_n;
            dec_src       <= op.fields.z;  // z is 7 (A) for the special opcodes
            dec_src_imm   <= src_imm_n;
            dec_imm       <= imm;
            dec_bit_index <= op.fields.y;
            dec_keep_z    <= keep_z_n;
            dec_write     <= write_n;
        end
    end

endmodule

//--- alu/alu.sv
`timescale 1ns/1ps

module alu
    import gb_alu_pkg::*;
(
    input  logic [7:0] alu_a,
    input  logic [7:0] alu_b,
    input  logic [2:0] alu_bit_index,
    input  logic [3:0] alu_flags_in,
    input  logic [4:0] alu_op,
    output logic [7:0] alu_result,
    output logic [3:0] alu_flags_out
);

    logic       carry;
    logic [4:0] sum_lo;
    logic [4:0] sum_hi;
    logic [8:0] daa_1;
    logic [8:0] daa_2;

    always_comb begin
        alu_result    = alu_b;
        alu_flags_out = 4'b0;
        carry         = 1'b0;
        sum_lo        = 5'd0;
        sum_hi        = 5'd0;
        daa_1         = 9'd0;
        daa_2         = 9'd0;
        case (alu_op)
            //////////////////////////////
            // Arithmetic and logic
            //////////////////////////////
            op_add, op_adc: begin
                carry  = (alu_op == op_adc) ? alu_flags_in[flag_c] : 1'b0;
                sum_lo = {1'b0, alu_a[3:0]} + {1'b0, alu_b[3:0]} + {4'b0, carry};
                sum_hi = {1'b0, alu_a[7:4]} + {1'b0, alu_b[7:4]} + {4'b0, sum_lo[4]};
                alu_result            = {sum_hi[3:0], sum_lo[3:0]};
                alu_flags_out[flag_h] = sum_lo[4];
                alu_flags_out[flag_c] = sum_hi[4];
                alu_flags_out[flag_z] = (alu_result == 8'd0);
            end
            op_sub, op_sbc, op_cp: begin
                // H and C come out as borrows
                carry  = (alu_op == op_sbc) ? alu_flags_in[flag_c] : 1'b0;
                sum_lo = {1'b0, alu_a[3:0]} + ~({1'b0, alu_b[3:0]} + {4'b0, carry}) + 5'd1;
                sum_hi = {1'b0, alu_a[7:4]} + ~{1'b0, alu_b[7:4]} + {4'b0, ~sum_lo[4]};
                alu_result            = (alu_op == op_cp) ? alu_a : {sum_hi[3:0], sum_lo[3:0]};
                alu_flags_out[flag_n] = 1'b1;
                alu_flags_out[flag_h] = sum_lo[4];
                alu_flags_out[flag_c] = sum_hi[4];
                alu_flags_out[flag_z] = ({sum_hi[3:0], sum_lo[3:0]} == 8'd0);
            end
            op_and: begin
                alu_result            = alu_a & alu_b;
                alu_flags_out[flag_h] = 1'b1;
                alu_flags_out[flag_z] = (alu_result == 8'd0);
            end
            op_xor: begin
                alu_result            = alu_a ^ alu_b;
                alu_flags_out[flag_z] = (alu_result == 8'd0);
            end
            op_or: begin
                alu_result            = alu_a | alu_b;
                alu_flags_out[flag_z] = (alu_result == 8'd0);
            end
            op_daa: begin
                if (!alu_flags_in[flag_n]) begin
                    if (alu_flags_in[flag_h] || (alu_a[3:0] > 4'd9))
                        daa_1 = {1'b0, alu_a} + 9'h06;
                    else
                        daa_1 = {1'b0, alu_a};
                    if (alu_flags_in[flag_c] || (daa_1 > 9'h9f))
                        daa_2 = daa_1 + 9'h60;
                    else
                        daa_2 = daa_1;
                end else begin
                    // After a subtraction only the recorded borrows adjust
                    if (alu_flags_in[flag_h])
                        daa_1 = {1'b0, alu_a - 8'h06};
                    else
                        daa_1 = {1'b0, alu_a};
                    if (alu_flags_in[flag_c])
                        daa_2 = daa_1 - 9'h60;
                    else
                        daa_2 = daa_1;
                end
                alu_result            = daa_2[7:0];
                alu_flags_out[flag_n] = alu_flags_in[flag_n];
                alu_flags_out[flag_c] = daa_2[8] | alu_flags_in[flag_c];
                alu_flags_out[flag_z] = (daa_2[7:0] == 8'd0);
            end
            op_cpl: begin
                alu_result            = ~alu_a;
                alu_flags_out         = alu_flags_in;
                alu_flags_out[flag_n] = 1'b1;
                alu_flags_out[flag_h] = 1'b1;
            end
            op_scf, op_ccf: begin
                alu_flags_out[flag_z] = alu_flags_in[flag_z];
                alu_flags_out[flag_c] = (alu_op == op_scf) ? 1'b1 : ~alu_flags_in[flag_c];
            end
            //////////////////////////////
            // Rotates and shifts
            //////////////////////////////
            op_rlc, op_rl, op_sla: begin
                alu_result[7:1] = alu_a[6:0];
                case (alu_op)
                    op_rlc:  alu_result[0] = alu_a[7];
                    op_rl:   alu_result[0] = alu_flags_in[flag_c];
                    default: alu_result[0] = 1'b0;
                endcase
                alu_flags_out[flag_c] = alu_a[7];
                alu_flags_out[flag_z] = (alu_result == 8'd0);
            end
            op_rrc, op_rr, op_sra, op_srl: begin
                alu_result[6:0] = alu_a[7:1];
                case (alu_op)
                    op_rrc:  alu_result[7] = alu_a[0];
                    op_rr:   alu_result[7] = alu_flags_in[flag_c];
                    op_sra:  alu_result[7] = alu_a[7];
                    default: alu_result[7] = 1'b0;
                endcase
                alu_flags_out[flag_c] = alu_a[0];
                alu_flags_out[flag_z] = (alu_result == 8'd0);
            end
            op_swap: begin
                alu_result            = {alu_a[3:0], alu_a[7:4]};
                alu_flags_out[flag_z] = (alu_a == 8'd0);
            end
            //////////////////////////////
            // Bit operations
            //////////////////////////////
            op_bit: begin
                alu_flags_out[flag_z] = ~alu_a[alu_bit_index];
                alu_flags_out[flag_h] = 1'b1;
                alu_flags_out[flag_c] = alu_flags_in[flag_c];
            end
            op_set, op_res: begin
                alu_result                = alu_a;
                alu_result[alu_bit_index] = (alu_op == op_set);
                alu_flags_out             = alu_flags_in;
            end
            default: begin
                // Load path passes b through untouched
                alu_flags_out = alu_flags_in;
            end
        endcase
    end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file
    import gb_alu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] rd_addr_a,
    input  logic [2:0] rd_addr_b,
    input  logic       wr_en,
    input  logic [2:0] wr_addr,
    input  logic [7:0] wr_data,
    output logic [7:0] rd_data_a,
    output logic [7:0] rd_data_b
);

    // B..L in slots 0-5, A folded into slot 6
    logic [7:0] regs [0:6];

    function automatic logic [2:0] slot(input logic [2:0] addr);
        return (addr == reg_a) ? 3'd6 : addr;
    endfunction

    assign rd_data_a = regs[slot(rd_addr_a)];
    assign rd_data_b = regs[slot(rd_addr_b)];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 7; i++) begin
                regs[i] <= 8'd0;
            end
        end else if (wr_en) begin
            regs[slot(wr_addr)] <= wr_data;
        end
    end

endmodule

//--- rtl/result_stage.sv
`timescale 1ns/1ps

module result_stage
    import gb_alu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       dec_valid,
    input  logic       dec_illegal,
    input  logic [2:0] dec_dst,
    input  logic       dec_write,
    input  logic       dec_keep_z,
    input  logic [7:0] alu_result,
    input  logic [3:0] alu_flags_out,
    output logic [3:0] flag_q,
    output logic       wr_en,
    output logic [2:0] wr_addr,
    output logic [7:0] wr_data,
    output logic       result_valid,
    output logic [7:0] result,
    output logic [3:0] flags,
    output logic       illegal
);

    logic [3:0] flags_n;

    // Accumulator rotates always leave Z clear
    always_comb begin
        flags_n = alu_flags_out;
        if (dec_keep_z)
            flags_n[flag_z] = 1'b0;
    end

    // Writeback lands on the same edge as result_valid
    assign wr_en   = dec_valid & dec_write;
    assign wr_addr = dec_dst;
    assign wr_data = alu_result;
    assign flags   = flag_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            flag_q       <= 4'd0;
            result_valid <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            result_valid <= dec_valid;
            illegal      <= dec_illegal;
            if (dec_valid)
                flag_q <= flags_n;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid)
            result <= alu_result;
    end

endmodule

//--- rtl/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
    input  logic       clk,
    input  logic       reset,
    input  logic       instr_valid,
    input  logic       instr_cb,
    input  logic [7:0] instr,
    input  logic [7:0] imm,
    output logic       result_valid,
    output logic [7:0] result,
    output logic [3:0] flags,
    output logic       illegal
);

    logic       dec_valid;
    logic       dec_illegal;
    logic [4:0] dec_op;
    logic [2:0] dec_dst;
    logic [2:0] dec_src;
    logic       dec_src_imm;
    logic [7:0] dec_imm;
    logic [2:0] dec_bit_index;
    logic       dec_keep_z;
    logic       dec_write;
    logic [7:0] rd_data_a;
    logic [7:0] rd_data_b;
    logic [7:0] alu_b;
    logic [7:0] alu_result;
    logic [3:0] alu_flags_out;
    logic [3:0] flag_q;
    logic       wr_en;
    logic [2:0] wr_addr;
    logic [7:0] wr_data;

    // Immediate forms replace read port b
    assign alu_b = dec_src_imm ? dec_imm : rd_data_b;

    opcode_decoder u_decoder (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr_cb      (instr_cb),
        .instr         (instr),
        .imm           (imm),
        .dec_valid     (dec_valid),
        .dec_illegal   (dec_illegal),
        .dec_op        (dec_op),
        .dec_dst       (dec_dst),
        .dec_src       (dec_src),
        .dec_src_imm   (dec_src_imm),
        .dec_imm       (dec_imm),
        .dec_bit_index (dec_bit_index),
        .dec_keep_z    (dec_keep_z),
        .dec_write     (dec_write)
    );

    register_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (dec_dst),
        .rd_addr_b (dec_src),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    alu u_alu (
        .alu_a         (rd_data_a),
        .alu_b         (alu_b),
        .alu_bit_index (dec_bit_index),
        .alu_flags_in  (flag_q),
        .alu_op        (dec_op),
        .alu_result    (alu_result),
        .alu_flags_out (alu_flags_out)
    );

    result_stage u_result (
        .clk           (clk),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec_illegal   (dec_illegal),
        .dec_dst       (dec_dst),
        .dec_write     (dec_write),
        .dec_keep_z    (dec_keep_z),
        .alu_result    (alu_result),
        .alu_flags_out (alu_flags_out),
        .flag_q        (flag_q),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .result_valid  (result_valid),
        .result        (result),
        .flags         (flags),
        .illegal       (illegal)
    );

endmodule

//--- sim/alu_exec_assertions.sv
`timescale 1ns/1ps

module alu_exec_assertions (
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input logic result_valid,
    input logic illegal
);

    int error_count;

    initial error_count = 0;

    // Never both at once
    assert property (@(posedge clk) disable iff (reset) !(result_valid && illegal))
        else begin
            $error("result_valid and illegal are high together");
            error_count++;
        end

    // Decode edge, then result edge
    assert property (@(posedge clk) disable iff (reset)
                     instr_valid |-> ##2 (result_valid != illegal))
        else begin
            $error("instruction not answered by exactly one of result_valid or illegal");
            error_count++;
        end

    assert property (@(posedge clk) (reset ##1 reset) |-> (!result_valid && !illegal))
        else begin
            $error("output pulse during reset");
            error_count++;
        end

endmodule

bind alu_exec alu_exec_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .result_valid (result_valid),
    .illegal      (illegal)
);

//--- sim/alu_exec_tb.sv
`timescale 1ns/1ps

module alu_exec_tb
    import gb_alu_pkg::*;
();

    logic       clk;
    logic       reset;
    logic       instr_valid;
    logic       instr_cb;
    logic [7:0] instr;
    logic [7:0] imm;
    logic       result_valid;
    logic [7:0] result;
    logic [3:0] flags;
    logic       illegal;

    // One entry per stimulus line
    logic       stim_cb[$];
    logic [7:0] stim_op[$];
    logic [7:0] stim_imm[$];
    logic [7:0] exp_result[$];
    logic [3:0] exp_flags[$];
    logic       exp_illegal[$];
    logic       stim_burst[$];

    // Instructions in flight, oldest first
    int         pending[$];
    int         issue_cycle[$];

    int         n_tests;
    int         cycles;
    int         cycle_limit;
    int         checked;
    int         pass_count;
    int         fail_count;
    bit         test_ok;
    int         idx;
    int         issued;
    gb_opcode_t opc;

    alu_exec alu_exec_i (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_cb     (instr_cb),
        .instr        (instr),
        .imm          (imm),
        .result_valid (result_valid),
        .result       (result),
        .flags        (flags),
        .illegal      (illegal)
    );

    always #2 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    count;
        string line;
        int    f_cb;
        int    f_op;
        int    f_imm;
        int    f_res;
        int    f_flags;
        int    f_ill;
        int    f_burst;
        fd = $fopen("sim/alu_exec_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/alu_exec_stim.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                count = $sscanf(line, "%h %h %h %h %h %h %h",
                                f_cb, f_op, f_imm, f_res, f_flags, f_ill, f_burst);
                if (count == 7) begin
                    stim_cb.push_back(f_cb[0]);
                    stim_op.push_back(f_op[7:0]);
                    stim_imm.push_back(f_imm[7:0]);
                    exp_result.push_back(f_res[7:0]);
                    exp_flags.push_back(f_flags[3:0]);
                    exp_illegal.push_back(f_ill[0]);
                    stim_burst.push_back(f_burst[0]);
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    // Cycle count and watchdog
    //////////////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////
    // Output checker
    //////////////////////////////

    always @(negedge clk) begin
        if (!reset && (result_valid || illegal)) begin
            if (pending.size() == 0) begin
                $display("Output pulse at %0t with no instruction in flight", $time);
                fail_count++;
            end else begin
                idx    = pending.pop_front();
                issued = issue_cycle.pop_front();
                opc    = stim_op[idx];
                test_ok = 1'b1;
                // Edges counted from the strobe edge
                compare_value("latency", 2, cycles - issued);
                compare_value("illegal", exp_illegal[idx], illegal);
                compare_value("result", exp_result[idx], result);
                compare_value("flags", exp_flags[idx], flags);
                if (test_ok) begin
                    pass_count++;
                    $display("Test %0d cb=%0d x=%0d y=%0d z=%0d ok", idx, stim_cb[idx],
                             opc.fields.x, opc.fields.y, opc.fields.z);
                end else begin
                    fail_count++;
                    $display("Test %0d cb=%0d x=%0d y=%0d z=%0d failed", idx, stim_cb[idx],
                             opc.fields.x, opc.fields.y, opc.fields.z);
                end
                checked++;
            end
        end
    end

    initial begin
        int gap;
        void'($urandom(32'hdf96c2e6));
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_cb    = 1'b0;
        instr       = 8'h00;
        imm         = 8'h00;
        load_stimulus();
        n_tests = stim_op.size();
        if (n_tests == 0) begin
            $display("No stimulus lines were loaded");
            $display("Verification failed");
            $finish;
        end else begin
            cycle_limit = 8 * n_tests + 100;
            repeat (10) @(posedge clk);
            reset <= 1'b0;
            for (int i = 0; i < n_tests; i++) begin
                gap = stim_burst[i] ? 0 : $urandom % 4;
                repeat (gap) begin
                    @(posedge clk);
                    instr_valid <= 1'b0;
                end
                @(posedge clk);
                instr_valid <= 1'b1;
                instr_cb    <= stim_cb[i];
                instr       <= stim_op[i];
                imm         <= stim_imm[i];
                pending.push_back(i);
                issue_cycle.push_back(cycles + 1);
            end
            @(posedge clk);
            instr_valid <= 1'b0;
            while (checked < n_tests) @(posedge clk);
            $display("Tests run: %0d, passed: %0d, failed: %0d, assertion errors: %0d",
                     n_tests, pass_count, fail_count, alu_exec_i.u_assertions.error_count);
            if (fail_count == 0 && alu_exec_i.u_assertions.error_count == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

//--- sim/alu_exec_stim.txt
# cb opcode imm | expected result flags illegal | burst (1 = issued with no idle gap)
# All fields hex, flags as {Z,N,H,C}
# Loads and the register ALU group
0 06 3a 3a 0 0 0
0 0e c6 c6 0 0 0
0 16 0f 0f 0 0 0
0 1e 01 01 0 0 0
0 26 f0 f0 0 0 0
0 2e 80 80 0 0 0
0 3e 3a 3a 0 0 0
0 81 00 00 b 0 0
0 8a 00 10 2 0 0
0 93 00 0f 6 0 0
0 98 00 d5 5 0 0
0 9b 00 d3 4 0 0
0 a4 00 d0 2 0 0
0 ad 00 50 0 0 0
0 b2 00 5f 0 0 0
0 b8 00 5f 4 0 0
0 bf 00 5f c 0 0
# Immediate forms and DAA
0 e6 00 00 a 0 0
0 f6 48 48 0 0 0
0 c6 39 81 2 0 0
0 27 00 87 0 0 0
0 ce 65 ec 0 0 0
0 27 00 52 1 0 0
0 d6 29 29 6 0 0
0 27 00 23 4 0 0
0 de 45 de 7 0 0
0 27 00 78 5 0 0
0 ee ff 87 0 0 0
0 fe 87 87 c 0 0
# Accumulator rotates, CPL, SCF, CCF
0 07 00 0f 1 0 0
0 1f 00 87 1 0 0
0 0f 00 c3 1 0 0
0 3f 00 c3 0 0 0
0 e6 80 80 2 0 0
0 17 00 00 1 0 0
0 2f 00 ff 7 0 0
0 fe ff ff c 0 0
0 37 00 ff 9 0 0
0 3f 00 ff 8 0 0
0 2f 00 00 e 0 0
# CB page
1 00 00 74 0 0 0
1 09 00 63 0 0 0
1 15 00 00 9 0 0
1 1b 00 80 1 0 0
1 22 00 1e 0 0 0
1 2b 00 c0 0 0 0
1 34 00 0f 0 0 0
1 37 00 00 8 0 0
1 39 00 31 1 0 0
1 7b 00 c0 3 0 0
1 40 00 74 b 0 0
1 a0 00 64 b 0 0
1 c7 00 01 b 0 0
1 fc 00 8f b 0 0
1 bb 00 40 b 0 0
# Illegal opcodes, then a carry-reading ADC
0 86 00 40 b 1 0
1 46 00 40 b 1 0
0 00 00 40 b 1 0
0 36 55 40 b 1 0
0 c3 00 40 b 1 0
0 8b 00 42 0 0 0
# Back-to-back dependent chain
0 06 19 19 0 0 0
0 80 00 5b 0 0 1
0 27 00 61 0 0 1
1 3f 00 30 1 0 1
0 90 00 17 6 0 1
1 37 00 71 0 0 1
0 af 00 00 8 0 1

//--- alu_exec.f
common/gb_alu_pkg.sv
rtl/opcode_decoder.sv
alu/alu.sv
rtl/register_file.sv
rtl/result_stage.sv
rtl/alu_exec.sv
sim/alu_exec_assertions.sv
sim/alu_exec_tb.sv
